// File: src/mem_pkg.sv
package mem_pkg;

    typedef logic [31:0] word_t;

    // one enable per byte lane.
    typedef logic [3:0] strobe_t;

    typedef enum logic [1:0] {
        MSIZE1 = 2'd0,
        MSIZE2 = 2'd1,
        MSIZE4 = 2'd2
    } msize_t;

    // beats minus one.
    typedef enum logic [3:0] {
        MLEN1  = 4'd0,
        MLEN2  = 4'd1,
        MLEN4  = 4'd3,
        MLEN8  = 4'd7,
        MLEN16 = 4'd15
    } mlen_t;

    localparam int WORD_BYTES = 4;
    localparam int NUM_WAYS = 4;

    localparam strobe_t STROBE_NONE = 4'b0000;
    localparam strobe_t STROBE_ALL = 4'b1111;

    // byte lanes that a transfer of this size may touch.
    function automatic strobe_t size_mask(input msize_t size, input logic [1:0] byte_off);
        case (size)
            MSIZE1: return strobe_t'(4'b0001 << byte_off);
            MSIZE2: return strobe_t'(4'b0011 << byte_off);
            default: return STROBE_ALL;
        endcase
    endfunction

endpackage

// File: src/dcache.sv
module dcache
    import mem_pkg::*;
#(
    parameter int OFFSET_BITS = 4,
    parameter int INDEX_BITS = 2
) (
    input  logic    clk,
    input  logic    resetn,

    input  logic    req_valid,
    input  word_t   req_addr,
    input  msize_t  req_size,
    input  strobe_t req_strobe,
    input  word_t   req_data,
    output logic    addr_ok,
    output logic    data_ok,
    output word_t   rdata,

    output logic    bus_valid,
    output logic    bus_is_write,
    output msize_t  bus_size,
    output word_t   bus_addr,
    output strobe_t bus_strobe,
    output word_t   bus_data,
    output mlen_t   bus_len,
    input  logic    bus_ready,
    input  word_t   bus_rdata,
    input  logic    bus_last
);
    localparam int BYTE_BITS = $clog2(WORD_BYTES);
    localparam int WORD_BITS = OFFSET_BITS - BYTE_BITS;
    localparam int LINE_WORDS = 1 << WORD_BITS;
    localparam int NUM_SETS = 1 << INDEX_BITS;
    localparam int TAG_BITS = 32 - OFFSET_BITS - INDEX_BITS;
    localparam int WAY_BITS = $clog2(NUM_WAYS);
    localparam mlen_t LINE_LEN = mlen_t'(LINE_WORDS - 1);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        FETCH,
        RESPOND
    } state_t;

    state_t state;

    logic [TAG_BITS-1:0] tag_q [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    logic [NUM_WAYS-1:0] dirty_q [NUM_SETS];
    word_t               line_q [NUM_SETS][NUM_WAYS][LINE_WORDS];

    word_t               req_addr_q;
    word_t               req_data_q;
    strobe_t             req_strobe_q;
    logic [WAY_BITS-1:0] way_q;
    logic [WORD_BITS-1:0] beat_q;

    logic [TAG_BITS-1:0]   req_tag;
    logic [INDEX_BITS-1:0] req_index;
    logic [WORD_BITS-1:0]  req_word;

    logic                hit;
    logic [WAY_BITS-1:0] hit_way;
    logic [WAY_BITS-1:0] victim_way;

    assign req_tag = req_addr_q[31 -: TAG_BITS];
    assign req_index = req_addr_q[OFFSET_BITS +: INDEX_BITS];
    assign req_word = req_addr_q[BYTE_BITS +: WORD_BITS];

    // xor of the four low way-sized slices of the tag.
    function automatic logic [WAY_BITS-1:0] fold_tag(input logic [TAG_BITS-1:0] tag);
        logic [WAY_BITS-1:0] h;
        h = '0;
        for (int i = 0; i < 4; i++) begin
            h = h ^ tag[i*WAY_BITS +: WAY_BITS];
        end
        return h;
    endfunction

    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_q[req_index][w] && tag_q[req_index][w] == req_tag) begin
                hit = 1'b1;
                hit_way = WAY_BITS'(w);
            end
        end
    end

    // lowest invalid way first, then the hashed way.
    always_comb begin
        victim_way = fold_tag(req_tag);
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[req_index][w]) begin
                victim_way = WAY_BITS'(w);
            end
        end
    end

    assign addr_ok = state == IDLE;
    assign data_ok = state == RESPOND;
    assign rdata = line_q[req_index][way_q][req_word];

    assign bus_valid = state == WRITEBACK || state == FETCH;
    assign bus_is_write = state == WRITEBACK;
    assign bus_size = MSIZE4;
    assign bus_addr = bus_is_write ? {tag_q[req_index][way_q], req_index, {OFFSET_BITS{1'b0}}}
                                   : {req_tag, req_index, {OFFSET_BITS{1'b0}}};
    assign bus_strobe = bus_is_write ? STROBE_ALL : STROBE_NONE;
    assign bus_data = line_q[req_index][way_q][beat_q];
    assign bus_len = LINE_LEN;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= IDLE;
            way_q <= '0;
            beat_q <= '0;
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
        end else begin
            case (state)
                IDLE: begin
                    if (req_valid) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    beat_q <= '0;
                    if (hit) begin
                        way_q <= hit_way;
                        state <= RESPOND;
                    end else begin
                        way_q <= victim_way;
                        if (valid_q[req_index][victim_way] && dirty_q[req_index][victim_way]) begin
                            state <= WRITEBACK;
                        end else begin
                            state <= FETCH;
                        end
                    end
                end
                WRITEBACK: begin
                    if (bus_ready) begin
                        beat_q <= beat_q + 1'b1;
                        if (bus_last) begin
                            beat_q <= '0;
                            dirty_q[req_index][way_q] <= 1'b0;
                            state <= FETCH;
                        end
                    end
                end
                FETCH: begin
                    if (bus_ready) begin
                        beat_q <= beat_q + 1'b1;
                        if (bus_last) begin
                            valid_q[req_index][way_q] <= 1'b1;
                            dirty_q[req_index][way_q] <= 1'b0;
                            state <= RESPOND;
                        end
                    end
                end
                RESPOND: begin
                    if (req_strobe_q != STROBE_NONE) begin
                        dirty_q[req_index][way_q] <= 1'b1;
                    end
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request, tags and line words.
    always_ff @(posedge clk) begin
        if (state == IDLE && req_valid) begin
            req_addr_q <= req_addr;
            req_data_q <= req_data;
            req_strobe_q <= req_strobe & size_mask(req_size, req_addr[1:0]);
        end
        if (state == FETCH && bus_ready) begin
            line_q[req_index][way_q][beat_q] <= bus_rdata;
            if (bus_last) begin
                tag_q[req_index][way_q] <= req_tag;
            end
        end
        if (state == RESPOND) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (req_strobe_q[b]) begin
                    line_q[req_index][way_q][req_word][8*b +: 8] <= req_data_q[8*b +: 8];
                end
            end
        end
    end

    a_burst_held: assert property (@(posedge clk) disable iff (resetn)
        bus_valid && !(bus_ready && bus_last) |=> bus_valid);

    // the answering way holds the requested line.
    a_respond_line: assert property (@(posedge clk) disable iff (resetn)
        data_ok |-> valid_q[req_index][way_q] && tag_q[req_index][way_q] == req_tag);

endmodule

// File: src/uncached_bridge.sv
module uncached_bridge
    import mem_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,

    input  logic    req_valid,
    input  word_t   req_addr,
    input  msize_t  req_size,
    input  strobe_t req_strobe,
    input  word_t   req_data,
    output logic    addr_ok,
    output logic    data_ok,
    output word_t   rdata,

    output logic    bus_valid,
    output logic    bus_is_write,
    output msize_t  bus_size,
    output word_t   bus_addr,
    output strobe_t bus_strobe,
    output word_t   bus_data,
    output mlen_t   bus_len,
    input  logic    bus_ready,
    input  word_t   bus_rdata,
    input  logic    bus_last
);
    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } state_t;

    state_t  state;
    word_t   addr_q;
    word_t   data_q;
    msize_t  size_q;
    strobe_t strobe_q;
    word_t   rdata_q;

    assign addr_ok = state == IDLE;
    assign data_ok = state == DONE;
    assign rdata = rdata_q;

    assign bus_valid = state == BUSY;
    assign bus_is_write = strobe_q != STROBE_NONE;
    assign bus_size = size_q;
    assign bus_addr = addr_q;
    assign bus_strobe = strobe_q;
    assign bus_data = data_q;
    assign bus_len = MLEN1;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (req_valid) state <= BUSY;
                BUSY: if (bus_ready && bus_last) state <= DONE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req_valid) begin
            addr_q <= req_addr;
            data_q <= req_data;
            size_q <= req_size;
            strobe_q <= req_strobe;
        end
        // read data is held for the response cycle.
        if (state == BUSY && bus_ready && bus_last) begin
            rdata_q <= bus_rdata;
        end
    end

    // the first completed beat ends the burst.
    a_single_beat: assert property (@(posedge clk) disable iff (resetn)
        bus_valid && bus_ready |=> !bus_valid);

endmodule

// File: src/cbus_arbiter.sv
module cbus_arbiter
    import mem_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,

    input  logic    m0_valid,
    input  logic    m0_is_write,
    input  msize_t  m0_size,
    input  word_t   m0_addr,
    input  strobe_t m0_strobe,
    input  word_t   m0_data,
    input  mlen_t   m0_len,
    output logic    m0_ready,
    output word_t   m0_rdata,
    output logic    m0_last,

    input  logic    m1_valid,
    input  logic    m1_is_write,
    input  msize_t  m1_size,
    input  word_t   m1_addr,
    input  strobe_t m1_strobe,
    input  word_t   m1_data,
    input  mlen_t   m1_len,
    output logic    m1_ready,
    output word_t   m1_rdata,
    output logic    m1_last,

    output logic    s_valid,
    output logic    s_is_write,
    output msize_t  s_size,
    output word_t   s_addr,
    output strobe_t s_strobe,
    output word_t   s_data,
    output mlen_t   s_len,
    input  logic    s_ready,
    input  word_t   s_rdata,
    input  logic    s_last
);
    logic locked_q;
    logic grant_q;
    logic last_q;
    logic grant;

    // round robin only when the bus is free.
    always_comb begin
        if (locked_q) begin
            grant = grant_q;
        end else if (m0_valid && m1_valid) begin
            grant = ~last_q;
        end else begin
            grant = m1_valid;
        end
    end

    assign s_valid = grant ? m1_valid : m0_valid;
    assign s_is_write = grant ? m1_is_write : m0_is_write;
    assign s_size = grant ? m1_size : m0_size;
    assign s_addr = grant ? m1_addr : m0_addr;
    assign s_strobe = grant ? m1_strobe : m0_strobe;
    assign s_data = grant ? m1_data : m0_data;
    assign s_len = grant ? m1_len : m0_len;

    assign m0_ready = s_ready && s_valid && !grant;
    assign m0_last = s_last && s_valid && !grant;
    assign m0_rdata = s_rdata;
    assign m1_ready = s_ready && s_valid && grant;
    assign m1_last = s_last && s_valid && grant;
    assign m1_rdata = s_rdata;

    // lock from the first presented beat until last completes.
    always_ff @(posedge clk) begin
        if (resetn) begin
            locked_q <= 1'b0;
            grant_q <= 1'b0;
            last_q <= 1'b1;
        end else if (s_valid && s_ready && s_last) begin
            locked_q <= 1'b0;
            last_q <= grant;
        end else if (s_valid) begin
            locked_q <= 1'b1;
            grant_q <= grant;
        end
    end

    a_grant_locked: assert property (@(posedge clk) disable iff (resetn)
        s_valid && !(s_ready && s_last) |=> s_valid && grant == $past(grant));

    a_grant_valid: assert property (@(posedge clk) disable iff (resetn)
        (m0_valid || m1_valid) |-> s_valid);

endmodule

// File: src/mem_subsys_top.sv
module mem_subsys_top
    import mem_pkg::*;
#(
    parameter int OFFSET_BITS = 4,
    parameter int INDEX_BITS = 2
) (
    input  logic    clk,
    input  logic    resetn,

    input  logic    d_valid,
    input  word_t   d_addr,
    input  msize_t  d_size,
    input  strobe_t d_strobe,
    input  word_t   d_data,
    output logic    d_addr_ok,
    output logic    d_data_ok,
    output word_t   d_rdata,

    input  logic    u_valid,
    input  word_t   u_addr,
    input  msize_t  u_size,
    input  strobe_t u_strobe,
    input  word_t   u_data,
    output logic    u_addr_ok,
    output logic    u_data_ok,
    output word_t   u_rdata,

    output logic    mem_valid,
    output logic    mem_is_write,
    output msize_t  mem_size,
    output word_t   mem_addr,
    output strobe_t mem_strobe,
    output word_t   mem_data,
    output mlen_t   mem_len,
    input  logic    mem_ready,
    input  word_t   mem_rdata,
    input  logic    mem_last
);
    // cache side of the arbiter.
    logic    c_valid;
    logic    c_is_write;
    msize_t  c_size;
    word_t   c_addr;
    strobe_t c_strobe;
    word_t   c_data;
    mlen_t   c_len;
    logic    c_ready;
    word_t   c_rdata;
    logic    c_last;

    // bridge side.
    logic    b_valid;
    logic    b_is_write;
    msize_t  b_size;
    word_t   b_addr;
    strobe_t b_strobe;
    word_t   b_data;
    mlen_t   b_len;
    logic    b_ready;
    word_t   b_rdata;
    logic    b_last;

    dcache #(
        .OFFSET_BITS(OFFSET_BITS),
        .INDEX_BITS(INDEX_BITS)
    ) dcache_i (
        .clk(clk), .resetn(resetn),
        .req_valid(d_valid), .req_addr(d_addr), .req_size(d_size),
        .req_strobe(d_strobe), .req_data(d_data),
        .addr_ok(d_addr_ok), .data_ok(d_data_ok), .rdata(d_rdata),
        .bus_valid(c_valid), .bus_is_write(c_is_write), .bus_size(c_size),
        .bus_addr(c_addr), .bus_strobe(c_strobe), .bus_data(c_data), .bus_len(c_len),
        .bus_ready(c_ready), .bus_rdata(c_rdata), .bus_last(c_last)
    );

    uncached_bridge bridge_i (
        .clk(clk), .resetn(resetn),
        .req_valid(u_valid), .req_addr(u_addr), .req_size(u_size),
        .req_strobe(u_strobe), .req_data(u_data),
        .addr_ok(u_addr_ok), .data_ok(u_data_ok), .rdata(u_rdata),
        .bus_valid(b_valid), .bus_is_write(b_is_write), .bus_size(b_size),
        .bus_addr(b_addr), .bus_strobe(b_strobe), .bus_data(b_data), .bus_len(b_len),
        .bus_ready(b_ready), .bus_rdata(b_rdata), .bus_last(b_last)
    );

    cbus_arbiter arb_i (
        .clk(clk), .resetn(resetn),
        .m0_valid(c_valid), .m0_is_write(c_is_write), .m0_size(c_size),
        .m0_addr(c_addr), .m0_strobe(c_strobe), .m0_data(c_data), .m0_len(c_len),
        .m0_ready(c_ready), .m0_rdata(c_rdata), .m0_last(c_last),
        .m1_valid(b_valid), .m1_is_write(b_is_write), .m1_size(b_size),
        .m1_addr(b_addr), .m1_strobe(b_strobe), .m1_data(b_data), .m1_len(b_len),
        .m1_ready(b_ready), .m1_rdata(b_rdata), .m1_last(b_last),
        .s_valid(mem_valid), .s_is_write(mem_is_write), .s_size(mem_size),
        .s_addr(mem_addr), .s_strobe(mem_strobe), .s_data(mem_data), .s_len(mem_len),
        .s_ready(mem_ready), .s_rdata(mem_rdata), .s_last(mem_last)
    );

endmodule

// File: sim/clk_gen.sv
module clk_gen #(
    parameter int HALF_PERIOD = 2,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic resetn
);
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // reset held high for the first cycles.
    initial begin
        resetn <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b0;
    end

endmodule

// File: sim/cbus_mem_model.sv
module cbus_mem_model
    import mem_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  logic    valid,
    input  logic    is_write,
    input  msize_t  size,
    input  word_t   addr,
    input  strobe_t strobe,
    input  word_t   data,
    input  mlen_t   len,
    output logic    ready,
    output word_t   rdata,
    output logic    last
);
    // cached lines at 0x0000_0000, uncached words at 0x8000_0000.
    word_t cmem [1024];
    word_t umem [64];

    logic [31:0] seed = 32'hd2e9_a577;
    logic        ready_q = 1'b0;
    logic        last_q = 1'b0;
    word_t       rdata_q = '0;
    logic        active = 1'b0;
    logic [3:0]  beat = '0;
    logic [1:0]  wait_cnt = '0;
    word_t       burst_addr = '0;
    logic        burst_write = 1'b0;
    mlen_t       burst_len = MLEN1;
    msize_t      burst_size = MSIZE4;
    word_t       beat_addr;
    int          interleave_errors = 0;

    assign ready = ready_q;
    assign rdata = rdata_q;
    assign last = last_q;
    assign beat_addr = burst_addr + {26'd0, beat, 2'b00};

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t fill_word(input word_t a);
        return (a * 32'h0001_0001) ^ 32'hc3a5_0f1e;
    endfunction

    function automatic word_t apply_strobe(input word_t old, input word_t d, input strobe_t s);
        word_t w;
        w = old;
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (s[b]) begin
                w[8*b +: 8] = d[8*b +: 8];
            end
        end
        return w;
    endfunction

    function automatic word_t read_word(input word_t a);
        if (a[31]) begin
            return umem[a[7:2]];
        end
        return cmem[a[11:2]];
    endfunction

    always @(posedge clk) begin
        if (resetn) begin
            ready_q <= 1'b0;
            last_q <= 1'b0;
            active <= 1'b0;
            for (int i = 0; i < 1024; i++) begin
                cmem[i] <= fill_word(word_t'(i) << 2);
            end
            for (int i = 0; i < 64; i++) begin
                umem[i] <= fill_word(32'h8000_0000 | (word_t'(i) << 2));
            end
        end else begin
            // any change of the held fields inside a burst.
            if (active && (!valid || addr != burst_addr || is_write != burst_write
                           || len != burst_len || size != burst_size)) begin
                interleave_errors <= interleave_errors + 1;
            end
            if (ready_q && valid) begin
                if (is_write && beat_addr[31]) begin
                    umem[beat_addr[7:2]] <= apply_strobe(umem[beat_addr[7:2]], data, strobe);
                end else if (is_write) begin
                    cmem[beat_addr[11:2]] <= apply_strobe(cmem[beat_addr[11:2]], data, strobe);
                end
                ready_q <= 1'b0;
                if (last_q) begin
                    last_q <= 1'b0;
                    active <= 1'b0;
                end else begin
                    beat <= beat + 1'b1;
                    wait_cnt <= seed[25:24];
                    seed <= lcg_next(seed);
                end
            end else if (valid && !active) begin
                active <= 1'b1;
                burst_addr <= addr;
                burst_write <= is_write;
                burst_len <= len;
                burst_size <= size;
                beat <= '0;
                wait_cnt <= seed[25:24];
                seed <= lcg_next(seed);
            end else if (active && !ready_q) begin
                if (wait_cnt == 2'd0) begin
                    ready_q <= 1'b1;
                    rdata_q <= read_word(beat_addr);
                    last_q <= beat == 4'(burst_len);
                end else begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
            end
        end
    end

endmodule

// File: sim/tb_top.sv
module tb_top
    import mem_pkg::*;
();
    localparam int OFFSET_BITS = 4;
    localparam int INDEX_BITS = 2;
    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_TESTS = 6;
    localparam int ACCESSES_PER_TEST = 17;
    // dirty miss at the longest ready waits, plus a lost arbitration.
    localparam int MISS_CYCLES = 64;
    localparam int WAIT_LIMIT = 2 * MISS_CYCLES;
    localparam int WATCHDOG_TIME =
        (RESET_CYCLES + NUM_TESTS * ACCESSES_PER_TEST * MISS_CYCLES) * CLK_PERIOD;

    logic    clk;
    logic    resetn;

    logic    d_valid;
    word_t   d_addr;
    msize_t  d_size;
    strobe_t d_strobe;
    word_t   d_data;
    logic    d_addr_ok;
    logic    d_data_ok;
    word_t   d_rdata;

    logic    u_valid;
    word_t   u_addr;
    msize_t  u_size;
    strobe_t u_strobe;
    word_t   u_data;
    logic    u_addr_ok;
    logic    u_data_ok;
    word_t   u_rdata;

    logic    mem_valid;
    logic    mem_is_write;
    msize_t  mem_size;
    word_t   mem_addr;
    strobe_t mem_strobe;
    word_t   mem_data;
    mlen_t   mem_len;
    logic    mem_ready;
    word_t   mem_rdata;
    logic    mem_last;

    // expected contents of written cached words, by word address.
    word_t shadow [word_t];
    int    test_errors = 0;
    int    pass_count = 0;
    int    fail_count = 0;

    clk_gen #(
        .HALF_PERIOD(CLK_PERIOD / 2),
        .RESET_CYCLES(RESET_CYCLES)
    ) clk_i (
        .clk(clk),
        .resetn(resetn)
    );

    mem_subsys_top #(
        .OFFSET_BITS(OFFSET_BITS),
        .INDEX_BITS(INDEX_BITS)
    ) dut_i (
        .clk(clk), .resetn(resetn),
        .d_valid(d_valid), .d_addr(d_addr), .d_size(d_size), .d_strobe(d_strobe),
        .d_data(d_data), .d_addr_ok(d_addr_ok), .d_data_ok(d_data_ok), .d_rdata(d_rdata),
        .u_valid(u_valid), .u_addr(u_addr), .u_size(u_size), .u_strobe(u_strobe),
        .u_data(u_data), .u_addr_ok(u_addr_ok), .u_data_ok(u_data_ok), .u_rdata(u_rdata),
        .mem_valid(mem_valid), .mem_is_write(mem_is_write), .mem_size(mem_size),
        .mem_addr(mem_addr), .mem_strobe(mem_strobe), .mem_data(mem_data),
        .mem_len(mem_len), .mem_ready(mem_ready), .mem_rdata(mem_rdata), .mem_last(mem_last)
    );

    cbus_mem_model mem_i (
        .clk(clk), .resetn(resetn),
        .valid(mem_valid), .is_write(mem_is_write), .size(mem_size), .addr(mem_addr),
        .strobe(mem_strobe), .data(mem_data), .len(mem_len),
        .ready(mem_ready), .rdata(mem_rdata), .last(mem_last)
    );

    function automatic word_t merge_bytes(input word_t old, input word_t data, input strobe_t s);
        word_t w;
        w = old;
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (s[b]) begin
                w[8*b +: 8] = data[8*b +: 8];
            end
        end
        return w;
    endfunction

    // never-written words still hold the memory contents.
    function automatic word_t expected_word(input word_t addr);
        word_t a;
        a = {addr[31:2], 2'b00};
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return mem_i.cmem[a[11:2]];
    endfunction

    function automatic word_t line_addr(input int tag, input int set);
        return word_t'((tag << (OFFSET_BITS + INDEX_BITS)) | (set << OFFSET_BITS));
    endfunction

    task automatic check_word(input string name, input word_t addr, input word_t got,
                              input word_t exp);
        assert (got === exp) else begin
            $display("FAIL %s at %h: got %h, expected %h", name, addr, got, exp);
            test_errors++;
        end
    endtask

    task automatic cached_access(input word_t addr, input msize_t size, input strobe_t strobe,
                                 input word_t data, output word_t rdata, output int lat);
        int   cyc;
        logic seen;
        cyc = 0;
        lat = 0;
        seen = 1'b0;
        @(posedge clk);
        d_valid <= 1'b1;
        d_addr <= addr;
        d_size <= size;
        d_strobe <= strobe;
        d_data <= data;
        do begin
            @(posedge clk);
            cyc++;
        end while (!d_addr_ok && cyc < WAIT_LIMIT);
        d_valid <= 1'b0;
        do begin
            @(posedge clk);
            lat++;
            seen = d_data_ok;
        end while (!seen && lat < WAIT_LIMIT);
        rdata = d_rdata;
        assert (seen) else begin
            $display("cached access to %h got no data_ok within %0d cycles", addr, WAIT_LIMIT);
            test_errors++;
        end
    endtask

    task automatic uncached_access(input word_t addr, input msize_t size, input strobe_t strobe,
                                   input word_t data, output word_t rdata);
        int   cyc;
        logic seen;
        cyc = 0;
        seen = 1'b0;
        @(posedge clk);
        u_valid <= 1'b1;
        u_addr <= addr;
        u_size <= size;
        u_strobe <= strobe;
        u_data <= data;
        do begin
            @(posedge clk);
            cyc++;
        end while (!u_addr_ok && cyc < WAIT_LIMIT);
        u_valid <= 1'b0;
        cyc = 0;
        do begin
            @(posedge clk);
            cyc++;
            seen = u_data_ok;
        end while (!seen && cyc < WAIT_LIMIT);
        rdata = u_rdata;
        assert (seen) else begin
            $display("uncached access to %h got no data_ok within %0d cycles", addr, WAIT_LIMIT);
            test_errors++;
        end
    endtask

    task automatic cached_write(input word_t addr, input msize_t size, input strobe_t strobe,
                                input word_t data);
        word_t rd;
        int    lat;
        shadow[{addr[31:2], 2'b00}] = merge_bytes(expected_word(addr), data, strobe);
        cached_access(addr, size, strobe, data, rd, lat);
    endtask

    task automatic cached_check(input word_t addr);
        word_t rd;
        int    lat;
        cached_access(addr, MSIZE4, STROBE_NONE, '0, rd, lat);
        check_word("d_rdata", addr, rd, expected_word(addr));
    endtask

    task automatic test_write_read();
        word_t addrs [5] = '{32'h100, 32'h114, 32'h128, 32'h13c, 32'h204};
        for (int i = 0; i < 5; i++) begin
            cached_write(addrs[i], MSIZE4, STROBE_ALL, 32'hc0de_0000 | addrs[i]);
        end
        for (int i = 0; i < 5; i++) begin
            cached_check(addrs[i]);
        end
        cached_write(addrs[0], MSIZE4, STROBE_ALL, 32'h0bad_f00d ^ addrs[0]);
        cached_write(addrs[2], MSIZE4, STROBE_ALL, 32'h0bad_f00d ^ addrs[2]);
        for (int i = 0; i < 5; i++) begin
            cached_check(addrs[i]);
        end
    endtask

    // five tags in set 2 overflow its four ways.
    task automatic test_eviction();
        word_t a;
        int    written_back;
        for (int i = 0; i < 5; i++) begin
            cached_write(line_addr(16 + i, 2), MSIZE4, STROBE_ALL, 32'h5e70_0000 + i);
        end
        for (int i = 0; i < 5; i++) begin
            cached_check(line_addr(16 + i, 2));
        end
        written_back = 0;
        for (int i = 0; i < 5; i++) begin
            a = line_addr(16 + i, 2);
            if (mem_i.cmem[a[11:2]] == shadow[a]) begin
                written_back++;
            end
        end
        assert (written_back >= 1) else begin
            $display("no evicted dirty line of set 2 was written back to memory");
            test_errors++;
        end
    endtask

    task automatic test_strobes();
        cached_write(32'h600, MSIZE4, STROBE_ALL, 32'h1122_3344);
        cached_write(32'h601, MSIZE1, 4'b0010, 32'h0000_aa00);
        cached_check(32'h600);
        cached_write(32'h602, MSIZE2, 4'b1100, 32'hbbcc_0000);
        cached_check(32'h600);
        cached_write(32'h603, MSIZE1, 4'b1000, 32'hdd00_0000);
        cached_write(32'h600, MSIZE1, 4'b0001, 32'h0000_00ee);
        cached_check(32'h600);
        cached_write(32'h604, MSIZE4, STROBE_ALL, 32'h0f1e_2d3c);
        cached_check(32'h604);
    endtask

    task automatic test_uncached();
        word_t old;
        word_t rd;
        uncached_access(32'h8000_0010, MSIZE4, STROBE_ALL, 32'h7777_1234, rd);
        check_word("umem", 32'h8000_0010, mem_i.umem[4], 32'h7777_1234);
        old = mem_i.umem[5];
        uncached_access(32'h8000_0014, MSIZE2, 4'b0011, 32'h0000_beef, rd);
        check_word("umem", 32'h8000_0014, mem_i.umem[5], merge_bytes(old, 32'hbeef, 4'b0011));
        check_word("mem_size", 32'h8000_0014, word_t'(mem_i.burst_size), word_t'(MSIZE2));
        uncached_access(32'h8000_0018, MSIZE4, STROBE_NONE, '0, rd);
        check_word("u_rdata", 32'h8000_0018, rd, mem_i.umem[6]);
        // cached lines are left as they were.
        cached_check(32'h100);
        cached_check(32'h604);
    endtask

    task automatic test_contention();
        word_t drd;
        word_t urd;
        int    lat;
        fork
            cached_access(32'h800, MSIZE4, STROBE_NONE, '0, drd, lat);
            uncached_access(32'h8000_0020, MSIZE4, STROBE_ALL, 32'h3c3c_a5a5, urd);
        join
        check_word("d_rdata", 32'h800, drd, expected_word(32'h800));
        check_word("umem", 32'h8000_0020, mem_i.umem[8], 32'h3c3c_a5a5);
        shadow[32'h840] = 32'h8400_0840;
        fork
            cached_access(32'h840, MSIZE4, STROBE_ALL, 32'h8400_0840, drd, lat);
            uncached_access(32'h8000_0018, MSIZE4, STROBE_NONE, '0, urd);
        join
        check_word("u_rdata", 32'h8000_0018, urd, mem_i.umem[6]);
        cached_check(32'h840);
        assert (mem_i.interleave_errors == 0) else begin
            $display("memory saw %0d beats that broke into a burst", mem_i.interleave_errors);
            test_errors++;
        end
    endtask

    task automatic test_hit_latency();
        word_t rd;
        int    lat;
        cached_check(32'h700);
        cached_access(32'h704, MSIZE4, STROBE_NONE, '0, rd, lat);
        check_word("d_rdata", 32'h704, rd, expected_word(32'h704));
        assert (lat == 2) else begin
            $display("FAIL d_data_ok latency: got %h cycles, expected %h", lat, 2);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("%s: passed", name);
        end else begin
            fail_count++;
            $display("%s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired after %0d time units", WATCHDOG_TIME);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        d_valid <= 1'b0;
        d_addr <= '0;
        d_size <= MSIZE4;
        d_strobe <= STROBE_NONE;
        d_data <= '0;
        u_valid <= 1'b0;
        u_addr <= '0;
        u_size <= MSIZE4;
        u_strobe <= STROBE_NONE;
        u_data <= '0;
        @(negedge resetn);
        test_write_read();
        finish_test("write_read");
        test_eviction();
        finish_test("eviction");
        test_strobes();
        finish_test("strobes");
        test_uncached();
        finish_test("uncached");
        test_contention();
        finish_test("contention");
        test_hit_latency();
        finish_test("hit_latency");
        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
src/mem_pkg.sv
src/dcache.sv
src/uncached_bridge.sv
src/cbus_arbiter.sv
src/mem_subsys_top.sv
sim/clk_gen.sv
sim/cbus_mem_model.sv
sim/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_top \
    -f list.f

output=$(./obj_dir/Vtb_top)
echo "$output"

if grep -qx "Simulation PASSED" <<< "$output"; then
    exit 0
fi
exit 1
